/* rtl/axil_reg_pkg.sv */
/* AXI-Lite register master package.
   Bus widths, response codes, engine state encodings and
   the known statistics register map of the RDMA engine. */

`default_nettype none

package axil_reg_pkg;

  typedef logic [31:0] axil_addr_t;  // byte address.
  typedef logic [31:0] axil_data_t;
  typedef logic [1:0]  axil_resp_t;

  localparam axil_resp_t AXIL_RESP_OKAY   = 2'b00;
  localparam axil_resp_t AXIL_RESP_SLVERR = 2'b10;

  typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_DATA, WR_RESP} wr_state_t;
  typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_t;

  ////////////////////////////////////////////////////////////
  // packet counters and status
  ////////////////////////////////////////////////////////////
  localparam axil_addr_t STAT_INSRRPKTCNT    = 32'h0002_0100;
  localparam axil_addr_t STAT_INAMPKTCNT     = 32'h0002_0104;
  localparam axil_addr_t STAT_OUTIOPKTCNT    = 32'h0002_0108;
  localparam axil_addr_t STAT_OUTAMPKTCNT    = 32'h0002_010c;
  localparam axil_addr_t STAT_LSTINPKT       = 32'h0002_0110;
  localparam axil_addr_t STAT_LSTOUTPKT      = 32'h0002_0114;
  localparam axil_addr_t STAT_ININVDUPCNT    = 32'h0002_0118;
  localparam axil_addr_t STAT_INNCKPKTSTS    = 32'h0002_011c;
  localparam axil_addr_t STAT_OUTRNRPKTSTS   = 32'h0002_0120;
  localparam axil_addr_t STAT_WQEPROCSTS     = 32'h0002_0124;
  localparam axil_addr_t STAT_QPMSTS         = 32'h0002_012c;
  localparam axil_addr_t STAT_INALLDRPPKTCNT = 32'h0002_0130;
  localparam axil_addr_t STAT_INNAKPKTCNT    = 32'h0002_0134;
  localparam axil_addr_t STAT_OUTNAKPKTCNT   = 32'h0002_0138;
  localparam axil_addr_t STAT_RESPHNDSTS     = 32'h0002_013c;
  localparam axil_addr_t STAT_RETRYCNTSTS    = 32'h0002_0140;
  localparam axil_addr_t STAT_INCNPPKTCNT    = 32'h0002_0174;
  localparam axil_addr_t STAT_OUTCNPPKTCNT   = 32'h0002_0178;
  localparam axil_addr_t STAT_OUTRDRSPPKTCNT = 32'h0002_017c;

  ////////////////////////////////////////////////////////////
  // interrupt status
  ////////////////////////////////////////////////////////////
  localparam axil_addr_t STAT_INTSTS         = 32'h0002_0184;
  localparam axil_addr_t STAT_RQINTSTS1      = 32'h0002_0190;
  localparam axil_addr_t STAT_RQINTSTS2      = 32'h0002_0194;
  localparam axil_addr_t STAT_RQINTSTS3      = 32'h0002_0198;
  localparam axil_addr_t STAT_RQINTSTS4      = 32'h0002_019c;
  localparam axil_addr_t STAT_RQINTSTS5      = 32'h0002_01a0;
  localparam axil_addr_t STAT_RQINTSTS6      = 32'h0002_01a4;
  localparam axil_addr_t STAT_RQINTSTS7      = 32'h0002_01a8;
  localparam axil_addr_t STAT_RQINTSTS8      = 32'h0002_01ac;
  localparam axil_addr_t STAT_CQINTSTS1      = 32'h0002_01b0;
  localparam axil_addr_t STAT_CQINTSTS2      = 32'h0002_01b4;
  localparam axil_addr_t STAT_CQINTSTS3      = 32'h0002_01b8;
  localparam axil_addr_t STAT_CQINTSTS4      = 32'h0002_01bc;
  localparam axil_addr_t STAT_CQINTSTS5      = 32'h0002_01c0;
  localparam axil_addr_t STAT_CQINTSTS6      = 32'h0002_01c4;
  localparam axil_addr_t STAT_CQINTSTS7      = 32'h0002_01c8;
  localparam axil_addr_t STAT_CQINTSTS8      = 32'h0002_01cc;

  // true when addr hits one entry of the map.
  function automatic logic is_stat_reg(input axil_addr_t addr);
    case (addr)
      STAT_INSRRPKTCNT, STAT_INAMPKTCNT, STAT_OUTIOPKTCNT, STAT_OUTAMPKTCNT,
      STAT_LSTINPKT, STAT_LSTOUTPKT, STAT_ININVDUPCNT, STAT_INNCKPKTSTS,
      STAT_OUTRNRPKTSTS, STAT_WQEPROCSTS, STAT_QPMSTS, STAT_INALLDRPPKTCNT,
      STAT_INNAKPKTCNT, STAT_OUTNAKPKTCNT, STAT_RESPHNDSTS, STAT_RETRYCNTSTS,
      STAT_INCNPPKTCNT, STAT_OUTCNPPKTCNT, STAT_OUTRDRSPPKTCNT,
      STAT_INTSTS,
      STAT_RQINTSTS1, STAT_RQINTSTS2, STAT_RQINTSTS3, STAT_RQINTSTS4,
      STAT_RQINTSTS5, STAT_RQINTSTS6, STAT_RQINTSTS7, STAT_RQINTSTS8,
      STAT_CQINTSTS1, STAT_CQINTSTS2, STAT_CQINTSTS3, STAT_CQINTSTS4,
      STAT_CQINTSTS5, STAT_CQINTSTS6, STAT_CQINTSTS7, STAT_CQINTSTS8:
        return 1'b1;
      default:
        return 1'b0;
    endcase
  endfunction

endpackage

`default_nettype wire

/* rtl/cfg_write_engine.sv */
/* Configuration write engine.
   Turns one write request into one AXI-Lite write (AW, W, B)
   and returns the write response with a done strobe. */

`timescale 1ns/10ps
`default_nettype none

module cfg_write_engine
  import axil_reg_pkg::*;
(
  input  wire             axil_clk,
  input  wire             axil_rstn,
  // requester side
  input  wire             cfg_req,
  input  wire axil_addr_t cfg_addr,
  input  wire axil_data_t cfg_data,
  output logic            cfg_busy,
  output logic            cfg_done,
  output axil_resp_t      cfg_resp,
  // AXI-Lite write channels
  output logic            awvalid,
  output axil_addr_t      awaddr,
  input  wire             awready,
  output logic            wvalid,
  output axil_data_t      wdata,
  input  wire             wready,
  input  wire             bvalid,
  input  wire axil_resp_t bresp,
  output logic            bready
);

  wr_state_t  wr_state;
  axil_addr_t addr_q;
  axil_data_t data_q;
  logic       accept;

  assign accept = cfg_req && !cfg_busy;

  always_ff @(posedge axil_clk) begin
    if (accept) begin
      addr_q <= cfg_addr;
      data_q <= cfg_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // one AXI-Lite phase per state
  ////////////////////////////////////////////////////////////
  always_ff @(posedge axil_clk) begin
    if (!axil_rstn) begin
      wr_state <= WR_IDLE;
      cfg_busy <= 1'b0;
      cfg_done <= 1'b0;
    end else begin
      cfg_done <= 1'b0;
      if (cfg_done) cfg_busy <= 1'b0;  // busy ends with the done cycle.
      case (wr_state)
        WR_IDLE: begin
          if (accept) begin
            wr_state <= WR_ADDR;
            cfg_busy <= 1'b1;
          end
        end
        WR_ADDR: begin
          if (awready) wr_state <= WR_DATA;
        end
        WR_DATA: begin
          if (wready) wr_state <= WR_RESP;
        end
        WR_RESP: begin
          if (bvalid) begin
            wr_state <= WR_IDLE;
            cfg_done <= 1'b1;
          end
        end
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge axil_clk) begin
    if (wr_state == WR_RESP && bvalid) cfg_resp <= bresp;
  end

  assign awvalid = (wr_state == WR_ADDR);
  assign awaddr  = addr_q;
  assign wvalid  = (wr_state == WR_DATA);  // held until wready.
  assign wdata   = data_q;
  assign bready  = (wr_state == WR_RESP);

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////
  a_req_not_busy: assert property (@(posedge axil_clk) disable iff (!axil_rstn)
    cfg_req |-> !cfg_busy)
    else $error("cfg_req while cfg_busy");

  a_aw_hold: assert property (@(posedge axil_clk) disable iff (!axil_rstn)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else $error("awaddr changed while waiting for awready");

  a_w_hold: assert property (@(posedge axil_clk) disable iff (!axil_rstn)
    wvalid && !wready |=> wvalid && $stable(wdata))
    else $error("wdata changed while waiting for wready");

endmodule

`default_nettype wire

/* rtl/stat_read_engine.sv */
/* Statistics read engine.
   Turns one read request into one AXI-Lite read (AR, R),
   returns data and response, and flags known statistics registers. */

`timescale 1ns/10ps
`default_nettype none

module stat_read_engine
  import axil_reg_pkg::*;
(
  input  wire             axil_clk,
  input  wire             axil_rstn,
  // requester side
  input  wire             stat_req,
  input  wire axil_addr_t stat_addr,
  output logic            stat_busy,
  output logic            stat_done,
  output axil_data_t      stat_data,
  output axil_resp_t      stat_resp,
  output logic            stat_known,
  // AXI-Lite read channels
  output logic            arvalid,
  output axil_addr_t      araddr,
  input  wire             arready,
  input  wire             rvalid,
  input  wire axil_data_t rdata,
  input  wire axil_resp_t rresp,
  output logic            rready
);

  rd_state_t  rd_state;
  axil_addr_t addr_q;
  logic       accept;
  logic       r_hs;

  assign accept = stat_req && !stat_busy;
  assign r_hs   = (rd_state == RD_DATA) && rvalid;

  ////////////////////////////////////////////////////////////
  // request capture
  ////////////////////////////////////////////////////////////
  // address classified once, when it is taken.
  always_ff @(posedge axil_clk) begin
    if (accept) begin
      addr_q     <= stat_addr;
      stat_known <= is_stat_reg(stat_addr);
    end
  end

  ////////////////////////////////////////////////////////////
  // AR and R phases
  ////////////////////////////////////////////////////////////
  always_ff @(posedge axil_clk) begin
    if (!axil_rstn) begin
      rd_state  <= RD_IDLE;
      stat_busy <= 1'b0;
      stat_done <= 1'b0;
    end else begin
      stat_done <= 1'b0;
      if (stat_done) stat_busy <= 1'b0;
      case (rd_state)
        RD_IDLE: begin
          if (accept) begin
            rd_state  <= RD_ADDR;
            stat_busy <= 1'b1;
          end
        end
        RD_ADDR: begin
          if (arready) rd_state <= RD_DATA;
        end
        RD_DATA: begin
          if (rvalid) begin
            rd_state  <= RD_IDLE;
            stat_done <= 1'b1;
          end
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  // any response code is passed on, SLVERR included.
  always_ff @(posedge axil_clk) begin
    if (r_hs) begin
      stat_data <= rdata;
      stat_resp <= rresp;
    end
  end

  assign arvalid = (rd_state == RD_ADDR);
  assign araddr  = addr_q;
  assign rready  = (rd_state == RD_DATA);  // always ready in the data phase.

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////
  a_req_not_busy: assert property (@(posedge axil_clk) disable iff (!axil_rstn)
    stat_req |-> !stat_busy)
    else $error("stat_req while stat_busy");

  a_ar_hold: assert property (@(posedge axil_clk) disable iff (!axil_rstn)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("araddr changed while waiting for arready");

endmodule

`default_nettype wire

/* rtl/axil_reg_master.sv */
/* AXI-Lite register master for the RDMA control port.
   Joins the configuration write engine and the statistics
   read engine to one AXI-Lite master port. */

`timescale 1ns/10ps
`default_nettype none

module axil_reg_master
  import axil_reg_pkg::*;
(
  input  wire             axil_clk,
  input  wire             axil_rstn,
  // configuration writes
  input  wire             cfg_req,
  input  wire axil_addr_t cfg_addr,
  input  wire axil_data_t cfg_data,
  output logic            cfg_busy,
  output logic            cfg_done,
  output axil_resp_t      cfg_resp,
  // statistics reads
  input  wire             stat_req,
  input  wire axil_addr_t stat_addr,
  output logic            stat_busy,
  output logic            stat_done,
  output axil_data_t      stat_data,
  output axil_resp_t      stat_resp,
  output logic            stat_known,
  // AXI-Lite master
  output logic            m_axil_awvalid,
  output axil_addr_t      m_axil_awaddr,
  input  wire             m_axil_awready,
  output logic            m_axil_wvalid,
  output axil_data_t      m_axil_wdata,
  input  wire             m_axil_wready,
  input  wire             m_axil_bvalid,
  input  wire axil_resp_t m_axil_bresp,
  output logic            m_axil_bready,
  output logic            m_axil_arvalid,
  output axil_addr_t      m_axil_araddr,
  input  wire             m_axil_arready,
  input  wire             m_axil_rvalid,
  input  wire axil_data_t m_axil_rdata,
  input  wire axil_resp_t m_axil_rresp,
  output logic            m_axil_rready
);

  // write channels only.
  cfg_write_engine u_cfg_write (
    .axil_clk  (axil_clk),
    .axil_rstn (axil_rstn),
    .cfg_req   (cfg_req),
    .cfg_addr  (cfg_addr),
    .cfg_data  (cfg_data),
    .cfg_busy  (cfg_busy),
    .cfg_done  (cfg_done),
    .cfg_resp  (cfg_resp),
    .awvalid   (m_axil_awvalid),
    .awaddr    (m_axil_awaddr),
    .awready   (m_axil_awready),
    .wvalid    (m_axil_wvalid),
    .wdata     (m_axil_wdata),
    .wready    (m_axil_wready),
    .bvalid    (m_axil_bvalid),
    .bresp     (m_axil_bresp),
    .bready    (m_axil_bready)
  );

  // read channels only.
  stat_read_engine u_stat_read (
    .axil_clk   (axil_clk),
    .axil_rstn  (axil_rstn),
    .stat_req   (stat_req),
    .stat_addr  (stat_addr),
    .stat_busy  (stat_busy),
    .stat_done  (stat_done),
    .stat_data  (stat_data),
    .stat_resp  (stat_resp),
    .stat_known (stat_known),
    .arvalid    (m_axil_arvalid),
    .araddr     (m_axil_araddr),
    .arready    (m_axil_arready),
    .rvalid     (m_axil_rvalid),
    .rdata      (m_axil_rdata),
    .rresp      (m_axil_rresp),
    .rready     (m_axil_rready)
  );

endmodule

`default_nettype wire

/* testbench/axil_slave_model.sv */
/* AXI-Lite register slave model.
   256 words at 0x00020000, each starting out with its own address.
   Outside the window writes are dropped, reads give 0xDEADBEEF, resp is SLVERR.
   Each ready and each response valid waits a random 0 to 3 cycles. */

`timescale 1ns/10ps
`default_nettype none

module axil_slave_model
  import axil_reg_pkg::*;
(
  input  wire             axil_clk,
  input  wire             axil_rstn,
  input  wire             awvalid,
  input  wire axil_addr_t awaddr,
  output logic            awready,
  input  wire             wvalid,
  input  wire axil_data_t wdata,
  output logic            wready,
  output logic            bvalid,
  output axil_resp_t      bresp,
  input  wire             bready,
  input  wire             arvalid,
  input  wire axil_addr_t araddr,
  output logic            arready,
  output logic            rvalid,
  output axil_data_t      rdata,
  output axil_resp_t      rresp,
  input  wire             rready
);

  axil_data_t mem [0:255];
  integer     seed = 32'h2af2_ec47;
  axil_addr_t wr_addr;
  logic [1:0] wr_ph;   // 0 address, 1 data, 2 response.
  logic       rd_ph;   // 0 address, 1 data.
  logic [1:0] wr_dly;
  logic [1:0] rd_dly;
  logic       aw_hs, w_hs, b_hs, ar_hs, r_hs;

  function automatic logic in_window(input axil_addr_t addr);
    return addr[31:10] == 22'h000080;
  endfunction

  function automatic logic [1:0] pick_delay();
    integer r;
    r = $random(seed);
    return r[1:0];
  endfunction

  initial begin
    for (int i = 0; i < 256; i++) mem[i] = 32'h0002_0000 | (i << 2);
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
    bresp   = AXIL_RESP_OKAY;
    arready = 1'b0;
    rvalid  = 1'b0;
    rdata   = '0;
    rresp   = AXIL_RESP_OKAY;
  end

  always @(posedge axil_clk) begin
    aw_hs <= awvalid && awready;
    w_hs  <= wvalid && wready;
    b_hs  <= bvalid && bready;
    ar_hs <= arvalid && arready;
    r_hs  <= rvalid && rready;
  end

  ////////////////////////////////////////////////////////////
  // outputs move on the falling edge only
  ////////////////////////////////////////////////////////////
  always @(negedge axil_clk) begin
    if (!axil_rstn) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
      wr_ph   <= 2'd0;
      rd_ph   <= 1'b0;
      wr_dly  <= 2'd0;
      rd_dly  <= 2'd0;
    end else begin
      case (wr_ph)
        2'd0: begin
          if (aw_hs) begin
            awready <= 1'b0;
            wr_addr <= awaddr;
            wr_ph   <= 2'd1;
            wr_dly  <= pick_delay();
          end else if (awvalid && !awready) begin
            if (wr_dly == 2'd0) awready <= 1'b1;
            else wr_dly <= wr_dly - 2'd1;
          end
        end
        2'd1: begin
          if (w_hs) begin
            wready <= 1'b0;
            if (in_window(wr_addr)) mem[wr_addr[9:2]] <= wdata;  // dropped outside.
            bresp  <= in_window(wr_addr) ? AXIL_RESP_OKAY : AXIL_RESP_SLVERR;
            wr_ph  <= 2'd2;
            wr_dly <= pick_delay();
          end else if (wvalid && !wready) begin
            if (wr_dly == 2'd0) wready <= 1'b1;
            else wr_dly <= wr_dly - 2'd1;
          end
        end
        default: begin
          if (b_hs) begin
            bvalid <= 1'b0;
            wr_ph  <= 2'd0;
            wr_dly <= pick_delay();
          end else if (!bvalid) begin
            if (wr_dly == 2'd0) bvalid <= 1'b1;
            else wr_dly <= wr_dly - 2'd1;
          end
        end
      endcase
      if (!rd_ph) begin
        if (ar_hs) begin
          arready <= 1'b0;
          rdata   <= in_window(araddr) ? mem[araddr[9:2]] : 32'hdead_beef;
          rresp   <= in_window(araddr) ? AXIL_RESP_OKAY : AXIL_RESP_SLVERR;
          rd_ph   <= 1'b1;
          rd_dly  <= pick_delay();
        end else if (arvalid && !arready) begin
          if (rd_dly == 2'd0) arready <= 1'b1;
          else rd_dly <= rd_dly - 2'd1;
        end
      end else begin
        if (r_hs) begin
          rvalid <= 1'b0;
          rd_ph  <= 1'b0;
          rd_dly <= pick_delay();
        end else if (!rvalid) begin
          if (rd_dly == 2'd0) rvalid <= 1'b1;
          else rd_dly <= rd_dly - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_axil_reg_master.sv */
/* Testbench for the AXI-Lite register master.
   Plays the stimulus file as write and read requests against the
   register slave model and checks every done strobe. */

`timescale 1ns/10ps
`default_nettype none

module tb_axil_reg_master
  import axil_reg_pkg::*;
();

  localparam int MAX_LINES = 64;

  logic       axil_clk;
  logic       axil_rstn;
  logic       cfg_req, cfg_busy, cfg_done;
  axil_addr_t cfg_addr;
  axil_data_t cfg_data;
  axil_resp_t cfg_resp;
  logic       stat_req, stat_busy, stat_done, stat_known;
  axil_addr_t stat_addr;
  axil_data_t stat_data;
  axil_resp_t stat_resp;
  logic       m_axil_awvalid, m_axil_awready, m_axil_wvalid, m_axil_wready;
  logic       m_axil_bvalid, m_axil_bready, m_axil_arvalid, m_axil_arready;
  logic       m_axil_rvalid, m_axil_rready;
  axil_addr_t m_axil_awaddr, m_axil_araddr;
  axil_data_t m_axil_wdata, m_axil_rdata;
  axil_resp_t m_axil_bresp, m_axil_rresp;

  logic [7:0] st_op    [0:MAX_LINES-1];
  axil_addr_t st_addr  [0:MAX_LINES-1];
  axil_data_t st_wdata [0:MAX_LINES-1];
  axil_data_t st_rdata [0:MAX_LINES-1];
  axil_resp_t st_resp  [0:MAX_LINES-1];
  int         n_lines = 0;
  int         err_cnt = 0;
  int         cycle_cnt = 0;
  int         cycle_limit = 100;
  logic       cfg_wait = 1'b0;
  logic       stat_wait = 1'b0;
  logic       cfg_done_q = 1'b0;
  logic       stat_done_q = 1'b0;
  axil_resp_t exp_cfg_resp, exp_stat_resp;
  axil_data_t exp_stat_data;
  logic       exp_known;

  axil_reg_master UUT (.*);

  axil_slave_model u_slave (
    .axil_clk  (axil_clk),
    .axil_rstn (axil_rstn),
    .awvalid   (m_axil_awvalid),
    .awaddr    (m_axil_awaddr),
    .awready   (m_axil_awready),
    .wvalid    (m_axil_wvalid),
    .wdata     (m_axil_wdata),
    .wready    (m_axil_wready),
    .bvalid    (m_axil_bvalid),
    .bresp     (m_axil_bresp),
    .bready    (m_axil_bready),
    .arvalid   (m_axil_arvalid),
    .araddr    (m_axil_araddr),
    .arready   (m_axil_arready),
    .rvalid    (m_axil_rvalid),
    .rdata     (m_axil_rdata),
    .rresp     (m_axil_rresp),
    .rready    (m_axil_rready)
  );

  initial axil_clk = 1'b0;
  always #5 axil_clk = ~axil_clk;

  always @(posedge axil_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles, a done strobe never arrived", cycle_cnt);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic report_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic check_data(input string name, input axil_data_t got, input axil_data_t exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_resp(input string name, input axil_resp_t got, input axil_resp_t exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // one falling edge, with the done strobes checked there
  ////////////////////////////////////////////////////////////
  task automatic next_cycle();
    @(negedge axil_clk);
    if (cfg_done_q && cfg_done) report_error("cfg_done wider than one cycle");
    if (cfg_done_q && cfg_busy) report_error("cfg_busy still high after cfg_done");
    if (cfg_done && !cfg_wait) report_error("cfg_done arrived with no write request");
    else if (cfg_done) begin
      check_resp("cfg_resp", cfg_resp, exp_cfg_resp);
      cfg_wait = 1'b0;
    end
    if (stat_done_q && stat_done) report_error("stat_done wider than one cycle");
    if (stat_done_q && stat_busy) report_error("stat_busy still high after stat_done");
    if (stat_done && !stat_wait) report_error("stat_done arrived with no read request");
    else if (stat_done) begin
      check_data("stat_data", stat_data, exp_stat_data);
      check_resp("stat_resp", stat_resp, exp_stat_resp);
      check_flag("stat_known", stat_known, exp_known);
      stat_wait = 1'b0;
    end
    cfg_done_q  = cfg_done;
    stat_done_q = stat_done;
  endtask

  initial begin
    int fd;
    int c;
    int n;
    axil_rstn = 1'b0;
    cfg_req   = 1'b0;
    cfg_addr  = '0;
    cfg_data  = '0;
    stat_req  = 1'b0;
    stat_addr = '0;
    fd = $fopen("testbench/axil_reg_stimulus.txt", "r");
    if (fd == 0) report_error("cannot open the stimulus file");
    while (fd != 0 && !$feof(fd)) begin
      c = $fgetc(fd);
      if (c == "#") begin
        while (c != "\n" && c != -1) c = $fgetc(fd);  // skip comment line.
      end else if ((c == "W" || c == "R" || c == "B") && n_lines < MAX_LINES) begin
        st_op[n_lines] = c[7:0];
        n = $fscanf(fd, "%h %h %h %h", st_addr[n_lines], st_wdata[n_lines],
                    st_rdata[n_lines], st_resp[n_lines]);
        if (n == 4) n_lines++;
        else report_error("malformed stimulus line");
      end
    end
    if (fd != 0) $fclose(fd);
    cycle_limit = 64 * n_lines + 100;

    repeat (8) @(negedge axil_clk);
    axil_rstn = 1'b1;
    repeat (8) begin
      next_cycle();
      check_flag("m_axil_awvalid", m_axil_awvalid, 1'b0);
      check_flag("m_axil_wvalid", m_axil_wvalid, 1'b0);
      check_flag("m_axil_bready", m_axil_bready, 1'b0);
      check_flag("m_axil_arvalid", m_axil_arvalid, 1'b0);
      check_flag("m_axil_rready", m_axil_rready, 1'b0);
      check_flag("cfg_busy", cfg_busy, 1'b0);
      check_flag("stat_busy", stat_busy, 1'b0);
      check_flag("cfg_done", cfg_done, 1'b0);
      check_flag("stat_done", stat_done, 1'b0);
    end

    for (int i = 0; i < n_lines; i++) begin
      if (cfg_busy || stat_busy) report_error("engine still busy before a new request");
      if (st_op[i] != "R") begin
        cfg_req      = 1'b1;
        cfg_addr     = st_addr[i];
        cfg_data     = st_wdata[i];
        exp_cfg_resp = st_resp[i];
        cfg_wait     = 1'b1;
      end
      if (st_op[i] != "W") begin
        stat_req      = 1'b1;
        stat_addr     = (st_op[i] == "B") ? st_addr[i] + 32'd4 : st_addr[i];  // next word.
        exp_stat_data = st_rdata[i];
        exp_stat_resp = st_resp[i];
        exp_known     = is_stat_reg(stat_addr);
        stat_wait     = 1'b1;
      end
      next_cycle();
      cfg_req  = 1'b0;
      stat_req = 1'b0;
      while (cfg_wait || stat_wait) next_cycle();
      next_cycle();  // strobe width and busy release.
    end
    repeat (4) next_cycle();

    $display("stimulus lines %0d, errors %0d", n_lines, err_cnt);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
rtl/axil_reg_pkg.sv
rtl/cfg_write_engine.sv
rtl/stat_read_engine.sv
rtl/axil_reg_master.sv
testbench/axil_slave_model.sv
testbench/tb_axil_reg_master.sv

/* testbench/axil_reg_stimulus.txt */
# columns: op addr wdata exp_rdata exp_resp, all hex; op W write, R read, B both
# B writes addr and reads addr+4 at once; unwritten window words hold their own address
W 00020010 12345678 00000000 0
R 00020010 00000000 12345678 0
W 00030000 cafef00d 00000000 2
R 00030000 00000000 deadbeef 2
R 00020184 00000000 00020184 0
R 000201cc 00000000 000201cc 0
R 00020200 00000000 00020200 0
W 00020100 a5a50001 00000000 0
R 00020100 00000000 a5a50001 0
B 00020020 0badc0de 00020024 0
B 00020030 11112222 00020034 0
R 00020020 00000000 0badc0de 0
R 00020030 00000000 11112222 0
B 00040000 55aa55aa deadbeef 2
R 00040000 00000000 deadbeef 2
R 000203fc 00000000 000203fc 0
